/* hdl/fxp_pkg.sv */
//--------------------------------------------------------------------
// Fixed-point unit package
// Q8.8 format constants, vector types, operation codes and the
// issue/result bundles shared by the register block and datapath
//--------------------------------------------------------------------
package fxp_pkg;

    //------------------------------------------------------------------
    // Q format
    //------------------------------------------------------------------
    // Integer bits include the sign
    localparam int FXP_INT_BITS  = 8;
    localparam int FXP_FRAC_BITS = 8;
    localparam int FXP_BITS      = FXP_INT_BITS + FXP_FRAC_BITS;

    // Operand/result word, signed Q8.8
    typedef logic signed [FXP_BITS-1:0] fxp_t;

    // Full precision, Q16.16 holds any product exactly
    typedef logic signed [2*FXP_BITS-1:0] fxp_wide_t;

    //------------------------------------------------------------------
    // Wishbone side
    //------------------------------------------------------------------
    localparam int WB_ADR_BITS  = 2;
    localparam int WB_DATA_BITS = 32;

    typedef logic [WB_ADR_BITS-1:0]  wb_adr_t;
    typedef logic [WB_DATA_BITS-1:0] wb_data_t;

    // Word addresses
    localparam wb_adr_t REG_OPA    = 2'd0;
    localparam wb_adr_t REG_OPB    = 2'd1;
    localparam wb_adr_t REG_CMD    = 2'd2;
    localparam wb_adr_t REG_RESULT = 2'd3;

    //------------------------------------------------------------------
    // Operations and pipeline bundles
    //------------------------------------------------------------------
    // Code 3 is not a legal operation
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fxp_op_e;

    // One issued operation
    typedef struct packed {
        logic    valid;
        fxp_op_e op;
        fxp_t    a;
        fxp_t    b;
    } fxp_issue_t;

    // One finished result
    typedef struct packed {
        logic valid;
        fxp_t value;
        logic overflow;
    } fxp_result_t;

endpackage

/* hdl/fxp_resize.sv */
//--------------------------------------------------------------------
// Fixed-point resize
// Converts a signed fixed-point value between integer/fraction widths
// with optional half-up rounding and saturation on overflow
//--------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_resize #(
    parameter int in_int   = 16,
    parameter int in_frac  = 16,
    parameter int out_int  = 8,
    parameter int out_frac = 8,
    parameter bit round_en = 1'b1
) (
    input  logic signed [in_int+in_frac-1:0]   in,
    output logic signed [out_int+out_frac-1:0] out,
    output logic                               overflow
);

    localparam int IW = in_int + in_frac;
    // Input integer part, output fraction
    localparam int MW = in_int + out_frac;
    localparam int OW = out_int + out_frac;
    // Narrower of the two integer parts sets the rounding ceiling
    localparam int GW = ((out_int < in_int) ? out_int : in_int) + out_frac;

    // Largest positive value that rounding may not step past
    localparam logic [MW-1:0] ROUND_LIMIT = {{(MW-GW+1){1'b0}}, {(GW-1){1'b1}}};

    logic signed [MW-1:0] mid;

    //------------------------------------------------------------------
    // Fraction part
    //------------------------------------------------------------------
    generate
        if (out_frac < in_frac) begin : g_frac_cut
            logic signed [MW-1:0] kept;

            assign kept = in[IW-1:in_frac-out_frac];

            if (round_en) begin : g_round
                // Highest dropped bit decides, except at the ceiling
                assign mid = (in[in_frac-out_frac-1] && (kept != ROUND_LIMIT)) ?
                             kept + MW'(1) : kept;
            end else begin : g_trunc
                assign mid = kept;
            end
        end else if (out_frac == in_frac) begin : g_frac_keep
            assign mid = in;
        end else begin : g_frac_pad
            assign mid = {in, {(out_frac-in_frac){1'b0}}};
        end
    endgenerate

    //------------------------------------------------------------------
    // Integer part
    //------------------------------------------------------------------
    generate
        if (out_int < in_int) begin : g_int_cut
            // Dropped integer bits plus the new sign bit
            logic [in_int-out_int:0] int_top;
            logic                    fits;

            assign int_top  = mid[MW-1:OW-1];
            assign fits     = (&int_top) || !(|int_top);
            assign overflow = !fits;

            always_comb begin
                if (fits) begin
                    out = mid[OW-1:0];
                end else if (mid[MW-1]) begin
                    out = {1'b1, {(OW-1){1'b0}}};
                end else begin
                    out = {1'b0, {(OW-1){1'b1}}};
                end
            end
        end else begin : g_int_extend
            assign overflow = 1'b0;
            // Signed size cast extends the sign
            assign out = OW'(mid);
        end
    endgenerate

    // Widening the integer part never saturates
    ap_no_widen_ovf: assert property (@(posedge overflow) in_int > out_int)
        else $error("fxp_resize: overflow while integer part is not narrowed");

endmodule

/* hdl/fxp_datapath.sv */
//--------------------------------------------------------------------
// Fixed-point datapath
// Two-stage add/sub/multiply pipeline, full precision in stage 1,
// rounded and saturated Q format result in stage 2
//--------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_datapath import fxp_pkg::*; #(
    parameter int int_bits  = FXP_INT_BITS,
    parameter int frac_bits = FXP_FRAC_BITS,
    parameter bit round_en  = 1'b1
) (
    input  logic        clk,
    input  logic        rstn,
    input  fxp_issue_t  issue,
    output fxp_result_t result
);

    localparam int MSB = int_bits + frac_bits - 1;

    fxp_wide_t a_wide;
    fxp_wide_t b_wide;
    fxp_wide_t s1_next;
    fxp_wide_t s1_value;
    logic      s1_valid;

    fxp_t      rs_value;
    logic      rs_overflow;

    fxp_t      s2_value;
    logic      s2_overflow;
    logic      s2_valid;

    //------------------------------------------------------------------
    // Stage 1: full precision
    //------------------------------------------------------------------
    // Align operands to the wide format for add/sub
    assign a_wide = {{int_bits{issue.a[MSB]}}, issue.a, {frac_bits{1'b0}}};
    assign b_wide = {{int_bits{issue.b[MSB]}}, issue.b, {frac_bits{1'b0}}};

    always_comb begin
        case (issue.op)
            OP_MUL:  s1_next = $signed(issue.a) * $signed(issue.b);
            OP_SUB:  s1_next = a_wide - b_wide;
            default: s1_next = a_wide + b_wide;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_value <= s1_next;
    end

    //------------------------------------------------------------------
    // Stage 2: round and saturate
    //------------------------------------------------------------------
    fxp_resize #(
        .in_int   (2 * int_bits),
        .in_frac  (2 * frac_bits),
        .out_int  (int_bits),
        .out_frac (frac_bits),
        .round_en (round_en)
    ) u_resize (
        .in       (s1_value),
        .out      (rs_value),
        .overflow (rs_overflow)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_value    <= rs_value;
        s2_overflow <= rs_overflow;
    end

    assign result = '{valid: s2_valid, value: s2_value, overflow: s2_overflow};

    // Register block only issues legal codes
    ap_legal_op: assert property (@(posedge clk) disable iff (!rstn)
        issue.valid |-> issue.op inside {OP_ADD, OP_SUB, OP_MUL});

    // Fixed two-cycle latency in both directions
    ap_latency: assert property (@(posedge clk) disable iff (!rstn)
        issue.valid |-> ##2 result.valid);
    ap_no_stray_result: assert property (@(posedge clk) disable iff (!rstn)
        result.valid |-> $past(issue.valid, 2));

endmodule

/* hdl/fxp_regs.sv */
//--------------------------------------------------------------------
// Fixed-point register block
// Wishbone classic slave with operand, command and result registers;
// issues operations to the datapath on legal command writes
//--------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_regs import fxp_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_adr_t     wb_adr,
    input  wb_data_t    wb_dat_w,
    output wb_data_t    wb_dat_r,
    output logic        wb_ack,
    output fxp_issue_t  issue,
    input  fxp_result_t result
);

    logic     req;
    logic     accept;
    logic     wr;
    fxp_op_e  cmd_op;
    logic     cmd_legal;
    logic     cmd_issue;
    wb_data_t rd_data;

    fxp_t     opa;
    fxp_t     opb;
    fxp_op_e  issue_op;
    logic     issue_valid;

    fxp_t     res_value;
    logic     res_overflow;
    logic     res_valid;

    //------------------------------------------------------------------
    // Bus decode
    //------------------------------------------------------------------
    assign req    = wb_cyc && wb_stb;
    // A request is taken once, ack drops it for the following cycle
    assign accept = req && !wb_ack;
    assign wr     = accept && wb_we;

    assign cmd_op    = fxp_op_e'(wb_dat_w[1:0]);
    assign cmd_legal = cmd_op inside {OP_ADD, OP_SUB, OP_MUL};
    assign cmd_issue = wr && (wb_adr == REG_CMD) && cmd_legal;

    always_comb begin
        case (wb_adr)
            REG_OPA:    rd_data = {16'd0, opa};
            REG_OPB:    rd_data = {16'd0, opb};
            REG_RESULT: rd_data = {14'd0, res_valid, res_overflow, res_value};
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack <= accept;
            if (accept && !wb_we) begin
                wb_dat_r <= rd_data;
            end
        end
    end

    //------------------------------------------------------------------
    // Operand registers
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            opa <= '0;
            opb <= '0;
        end else if (wr) begin
            if (wb_adr == REG_OPA) begin
                opa <= wb_dat_w[15:0];
            end
            if (wb_adr == REG_OPB) begin
                opb <= wb_dat_w[15:0];
            end
        end
    end

    //------------------------------------------------------------------
    // Command issue
    //------------------------------------------------------------------
    // One-cycle pulse after the accepting edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= 1'b0;
            issue_op    <= OP_ADD;
        end else begin
            issue_valid <= cmd_issue;
            if (cmd_issue) begin
                issue_op <= cmd_op;
            end
        end
    end

    // Operands stay stable while the pulse is high
    assign issue = '{valid: issue_valid, op: issue_op, a: opa, b: opb};

    //------------------------------------------------------------------
    // Result capture
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_value    <= '0;
            res_overflow <= 1'b0;
            res_valid    <= 1'b0;
        end else begin
            if (result.valid) begin
                res_value    <= result.value;
                res_overflow <= result.overflow;
                res_valid    <= 1'b1;
            end
            // New command wins over a result arriving on the same edge
            if (cmd_issue) begin
                res_valid <= 1'b0;
            end
        end
    end

    // Single-cycle ack, always answering a request
    ap_ack_single: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |-> !$past(wb_ack) && $past(wb_cyc && wb_stb));

endmodule

/* hdl/fxp_unit_top.sv */
//--------------------------------------------------------------------
// Fixed-point unit top level
// Wishbone register block steering the add/sub/multiply datapath
//--------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_unit_top import fxp_pkg::*; #(
    parameter int int_bits  = FXP_INT_BITS,
    parameter int frac_bits = FXP_FRAC_BITS,
    parameter bit round_en  = 1'b1
) (
    input  logic     clk,
    input  logic     rstn,
    // Wishbone classic slave
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_adr_t  wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack
);

    fxp_issue_t  issue;
    fxp_result_t result;

    fxp_regs u_regs (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .issue    (issue),
        .result   (result)
    );

    // Two-cycle pipeline, result lands back in the register block
    fxp_datapath #(
        .int_bits  (int_bits),
        .frac_bits (frac_bits),
        .round_en  (round_en)
    ) u_datapath (
        .clk    (clk),
        .rstn   (rstn),
        .issue  (issue),
        .result (result)
    );

endmodule

/* tests/fxp_unit_tb.sv */
//--------------------------------------------------------------------
// Fixed-point unit testbench
// Drives the Wishbone register block from a vector file and checks
// results against the Q8.8 rounding and saturation rules
//--------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_unit_tb import fxp_pkg::*; ();

    localparam int MAX_TESTS  = 64;
    localparam int STIM_WORDS = 5 * MAX_TESTS;
    localparam int ACK_LIMIT  = 10;
    localparam int POLL_LIMIT = 10;

    // One line of the vector file
    typedef struct packed {
        logic [1:0] op;
        fxp_t       a;
        fxp_t       b;
        fxp_t       value;
        logic       overflow;
    } vector_t;

    logic     clk;
    logic     rstn;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_adr_t  wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    logic [15:0] stim_mem [STIM_WORDS];
    vector_t     vectors [MAX_TESTS];
    int          num_tests   = 0;
    int          cycle_limit = 100;
    int          cycle_count = 0;
    int          test_num    = 0;
    int          test_errors = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;

    fxp_unit_top uut (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    //------------------------------------------------------------------
    // Reference model and checks
    //------------------------------------------------------------------
    function automatic fxp_result_t rule_result(logic [1:0] op, fxp_t a, fxp_t b);
        longint      exact;
        longint      unrounded;
        fxp_result_t r;
        case (op)
            2'd0: exact = longint'(a) + longint'(b);
            2'd1: exact = longint'(a) - longint'(b);
            default: begin
                exact     = longint'(a) * longint'(b);
                unrounded = exact >>> 8;
                // No rounding step past the largest positive value
                if (unrounded != 32767) begin
                    exact = exact + 128;
                end
                exact = exact >>> 8;
            end
        endcase
        r.valid    = 1'b1;
        r.overflow = (exact > 32767) || (exact < -32768);
        if (exact > 32767) begin
            r.value = 16'h7FFF;
        end else if (exact < -32768) begin
            r.value = 16'h8000;
        end else begin
            r.value = exact[15:0];
        end
        return r;
    endfunction

    function automatic string op_name(logic [1:0] op);
        case (op)
            2'd0:    return "add";
            2'd1:    return "sub";
            2'd2:    return "mul";
            default: return "illegal";
        endcase
    endfunction

    task automatic check_fxp(input string name, input fxp_t expected, input fxp_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string desc);
        test_num++;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d passed: %s", test_num, desc);
        end else begin
            fail_count++;
            $display("test %0d failed: %s (%0d errors)", test_num, desc, test_errors);
        end
        test_errors = 0;
    endtask

    //------------------------------------------------------------------
    // Wishbone master
    //------------------------------------------------------------------
    // Sampled on the falling edge, away from the slave's update
    task automatic await_ack(output logic seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited <= ACK_LIMIT) begin
            @(negedge clk);
            seen = wb_ack;
            waited++;
        end
        if (!seen) begin
            $display("Error at %0t ns: missing acknowledge, slave did not answer in %0d cycles",
                     $time, ACK_LIMIT);
            test_errors++;
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
        logic seen;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        await_ack(seen);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
        logic seen;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        await_ack(seen);
        data = seen ? wb_dat_r : '0;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // Read RESULT until its valid bit is set
    task automatic wait_result(output wb_data_t data);
        int polls;
        polls = 0;
        wb_read(REG_RESULT, data);
        while (!data[17] && polls < POLL_LIMIT) begin
            wb_read(REG_RESULT, data);
            polls++;
        end
        if (!data[17]) begin
            $display("Error at %0t ns: result valid flag never set", $time);
            test_errors++;
        end
    endtask

    //------------------------------------------------------------------
    // Tests
    //------------------------------------------------------------------
    task automatic load_stimulus();
        int base;
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim_mem[i] = 16'hE000 | 16'(i);
        end
        $readmemh("tests/fxp_stimulus.txt", stim_mem);
        // Fill words are never a legal op column
        while (num_tests < MAX_TESTS && stim_mem[5 * num_tests] <= 16'd3) begin
            base = 5 * num_tests;
            vectors[num_tests].op       = stim_mem[base][1:0];
            vectors[num_tests].a        = stim_mem[base + 1];
            vectors[num_tests].b        = stim_mem[base + 2];
            vectors[num_tests].value    = stim_mem[base + 3];
            vectors[num_tests].overflow = stim_mem[base + 4][0];
            num_tests++;
        end
        cycle_limit = 40 * num_tests + 100;
        if (num_tests == 0) begin
            $display("Error: no vectors found in the stimulus file");
            fail_count++;
        end
    endtask

    task automatic run_vector(input int idx);
        vector_t     vec;
        fxp_result_t model;
        wb_data_t    data;
        vec   = vectors[idx];
        model = rule_result(vec.op, vec.a, vec.b);
        if (model.value !== vec.value || model.overflow !== vec.overflow) begin
            $display("Error: vector %0d in the file disagrees with the rounding rule (%h/%b)",
                     idx, model.value, model.overflow);
            test_errors++;
        end
        wb_write(REG_OPA, {16'd0, vec.a});
        wb_write(REG_OPB, {16'd0, vec.b});
        wb_write(REG_CMD, {30'd0, vec.op});
        wait_result(data);
        check_fxp("result.value", vec.value, data[15:0]);
        check_flag("result.overflow", vec.overflow, data[16]);
        finish_test($sformatf("%s %h %h -> %h overflow %b", op_name(vec.op),
                              vec.a, vec.b, vec.value, vec.overflow));
    endtask

    initial begin : main
        wb_data_t data;
        vector_t  last;
        rstn     <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= REG_OPA;
        wb_dat_w <= '0;
        load_stimulus();
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        wb_read(REG_RESULT, data);
        check_fxp("result.value", 16'h0000, data[15:0]);
        check_flag("result.overflow", 1'b0, data[16]);
        check_flag("result.valid", 1'b0, data[17]);
        finish_test("RESULT reads zero after reset");

        wb_write(REG_OPA, 32'h0000_A5C3);
        wb_write(REG_OPB, 32'h0000_8001);
        wb_read(REG_OPA, data);
        check_fxp("opa", 16'hA5C3, data[15:0]);
        wb_read(REG_OPB, data);
        check_fxp("opb", 16'h8001, data[15:0]);
        finish_test("OPA and OPB read back");

        for (int i = 0; i < num_tests; i++) begin
            run_vector(i);
        end

        // Code 3 on fresh operands must not disturb the last result
        if (num_tests > 0) begin
            last = vectors[num_tests - 1];
            wb_write(REG_OPA, 32'h0000_0100);
            wb_write(REG_OPB, 32'h0000_0100);
            wb_write(REG_CMD, 32'h0000_0003);
            repeat (4) @(posedge clk);
            wb_read(REG_RESULT, data);
            check_fxp("result.value", last.value, data[15:0]);
            check_flag("result.overflow", last.overflow, data[16]);
            check_flag("result.valid", 1'b1, data[17]);
            finish_test("illegal command code 3 is ignored");
        end

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tests/fxp_stimulus.txt */
// op a b result ovf, all hex; op 0 = add, 1 = sub, 2 = mul
// result and ovf are the expected Q8.8 value and overflow flag
0 0100 0200 0300 0
0 0340 FD80 00C0 0
0 FF00 FE80 FD80 0
0 7FFF 0000 7FFF 0
0 7F00 0100 7FFF 1
0 8000 FF00 8000 1
1 0500 0200 0300 0
1 0100 0340 FDC0 0
1 FF80 FF00 0080 0
1 8000 0001 8000 1
1 7F00 FF00 7FFF 1
2 0200 0180 0300 0
2 FF00 0280 FD80 0
2 0180 FE80 FDC0 0
2 0001 0080 0001 0
2 0001 007F 0000 0
2 0001 0081 0001 0
2 0003 0080 0002 0
2 FFFF 0080 0000 0
2 FFFD 0080 FFFF 0
2 FFFF 0081 FFFF 0
2 1111 0780 7FFF 0
2 1000 1000 7FFF 1
2 1000 F000 8000 1
2 8000 8000 7FFF 1
2 0180 FE80 FDC0 0

/* compile.f */
hdl/fxp_pkg.sv
hdl/fxp_resize.sv
hdl/fxp_datapath.sv
hdl/fxp_regs.sv
hdl/fxp_unit_top.sv
tests/fxp_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fixed-point unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module fxp_unit_tb -o fxp_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fxp_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

exit 0
